// File: verilog.f
+incdir+.
fetch_pkg.sv
fetch_pc.sv
branch_resolve.sv
exc_flush_ctrl.sv
npc.sv
fetch_redirect_top.sv
fetch_redirect_properties.sv
tb_fetch_redirect.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_fetch_redirect -f verilog.f -o sim_fetch_redirect

status=0
output=$(./obj_dir/sim_fetch_redirect) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -q "No errors"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tb_fetch_redirect.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_redirect
	import fetch_pkg::*;
();

	localparam int unsigned MAX_CYCLES = 400; // 16 reset cycles plus about 60 test cycles

	logic    clk;
	logic    rst;
	logic    can_go;
	logic    ex_valid;
	npc_op_t ex_npc_op;
	addr_t   ex_pc;
	logic    ex_taken;
	addr_t   ex_branch_target;
	addr_t   ex_jump_target;
	addr_t   ex_ret_addr;
	addr_t   ex_fetched_npc;
	logic    mem1_exception;
	logic    mem1_eret;
	addr_t   mem1_pc;
	addr_t   pc;
	addr_t   npc;
	logic    instr_flush;
	logic    if_flush;
	logic    id_flush;
	logic    ex_flush;
	logic    mem1_flush;

	addr_t       exp_pc;
	addr_t       exp_epc;
	int unsigned cycles = 0;

	fetch_redirect_top DUT (
		.clk              (clk),
		.rst              (rst),
		.can_go           (can_go),
		.ex_valid         (ex_valid),
		.ex_npc_op        (ex_npc_op),
		.ex_pc            (ex_pc),
		.ex_taken         (ex_taken),
		.ex_branch_target (ex_branch_target),
		.ex_jump_target   (ex_jump_target),
		.ex_ret_addr      (ex_ret_addr),
		.ex_fetched_npc   (ex_fetched_npc),
		.mem1_exception   (mem1_exception),
		.mem1_eret        (mem1_eret),
		.mem1_pc          (mem1_pc),
		.pc               (pc),
		.npc              (npc),
		.instr_flush      (instr_flush),
		.if_flush         (if_flush),
		.id_flush         (id_flush),
		.ex_flush         (ex_flush),
		.mem1_flush       (mem1_flush)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			stop_on_failure();
		end
	end

	task automatic stop_on_failure;
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_addr(input string what, input addr_t got, input addr_t exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flushes(input logic exp_instr, input logic exp_front, input logic exp_mem1);
		check_bit("instr_flush", instr_flush, exp_instr);
		check_bit("if_flush", if_flush, exp_front);
		check_bit("id_flush", id_flush, exp_front);
		check_bit("ex_flush", ex_flush, exp_front);
		check_bit("mem1_flush", mem1_flush, exp_mem1);
	endtask

	// Next drive point, 1 ns after the rising edge
	task automatic step;
		@(posedge clk);
		#1;
	endtask

	task automatic settle;
		#1;
	endtask

	function automatic addr_t rand_addr();
		rand_addr = $urandom() & 32'hFFFF_FFFC; // Word aligned
	endfunction

	// Real successor of the EX instruction
	function automatic addr_t expected_target();
		case (ex_npc_op)
			NPC_SEQ:    expected_target = ex_pc + 32'd4;
			NPC_BRANCH: expected_target = ex_taken ? ex_branch_target : ex_pc + 32'd4;
			NPC_JUMP:   expected_target = ex_jump_target;
			default:    expected_target = ex_ret_addr;
		endcase
	endfunction

	task automatic idle_inputs;
		can_go           = 1'b1;
		ex_valid         = 1'b0;
		ex_npc_op        = NPC_SEQ;
		ex_pc            = '0;
		ex_taken         = 1'b0;
		ex_branch_target = '0;
		ex_jump_target   = '0;
		ex_ret_addr      = '0;
		ex_fetched_npc   = '0;
		mem1_exception   = 1'b0;
		mem1_eret        = 1'b0;
		mem1_pc          = '0;
	endtask

	task automatic load_ex(input npc_op_t op, input logic taken);
		ex_valid         = 1'b1;
		ex_npc_op        = op;
		ex_taken         = taken;
		ex_pc            = rand_addr();
		ex_branch_target = rand_addr();
		ex_jump_target   = rand_addr();
		ex_ret_addr      = rand_addr();
	endtask

	task automatic raise_mem1(input logic exc, input logic eret, input addr_t fault_pc);
		mem1_exception = exc;
		mem1_eret      = eret;
		mem1_pc        = fault_pc;
	endtask

	task automatic test_sequential_fetch;
		check_addr("pc after reset", pc, `RESET_PC);
		repeat (4) begin
			settle();
			check_addr("npc", npc, exp_pc + 32'd4);
			check_flushes(1'b0, 1'b0, 1'b0);
			step();
			exp_pc = exp_pc + 32'd4;
			check_addr("pc", pc, exp_pc);
		end
		can_go = 1'b0; // Stall, pc must hold
		repeat (3) begin
			settle();
			check_addr("npc while stalled", npc, exp_pc + 32'd4);
			step();
			check_addr("pc while stalled", pc, exp_pc);
		end
		can_go = 1'b1;
	endtask

	task automatic test_correct_predict;
		for (int i = 0; i < 8; i++) begin
			load_ex(npc_op_t'(i[2:1]), i[0]);
			ex_fetched_npc = expected_target();
			settle();
			check_bit("instr_flush", instr_flush, 1'b0);
			check_addr("npc", npc, exp_pc + 32'd4);
			step();
			exp_pc = exp_pc + 32'd4;
			check_addr("pc", pc, exp_pc);
		end
		idle_inputs();
	endtask

	task automatic test_mispredict;
		addr_t cand;
		for (int i = 0; i < 8; i++) begin
			load_ex(npc_op_t'(i[2:1]), i[0]);
			cand = expected_target();
			ex_fetched_npc = cand ^ 32'h0000_0010;
			settle();
			check_bit("instr_flush", instr_flush, 1'b1);
			check_addr("npc", npc, cand);
			step();
			exp_pc = cand;
			check_addr("pc after redirect", pc, exp_pc);
		end
		ex_valid = 1'b0; // Wrong fetch, but a bubble
		settle();
		check_bit("instr_flush for bubble", instr_flush, 1'b0);
		check_addr("npc for bubble", npc, exp_pc + 32'd4);
		step();
		exp_pc = exp_pc + 32'd4;
		check_addr("pc", pc, exp_pc);
		idle_inputs();
	endtask

	task automatic test_exception_priority;
		addr_t fault_pc;
		fault_pc = rand_addr();
		load_ex(NPC_BRANCH, 1'b1);
		ex_fetched_npc = ex_branch_target ^ 32'h0000_0010;
		raise_mem1(1'b1, 1'b0, fault_pc);
		can_go = 1'b0;
		settle();
		check_addr("npc on exception", npc, `EXC_VECTOR);
		check_flushes(1'b1, 1'b1, 1'b0);
		step();
		check_addr("pc while stalled", pc, exp_pc);
		can_go = 1'b1;
		settle();
		check_addr("npc on exception", npc, `EXC_VECTOR);
		check_flushes(1'b1, 1'b1, 1'b1);
		step();
		exp_pc = `EXC_VECTOR;
		exp_epc = fault_pc;
		check_addr("pc after exception", pc, exp_pc);
		idle_inputs();
	endtask

	task automatic test_eret_epc;
		addr_t first_pc;
		addr_t second_pc;
		addr_t third_pc;
		first_pc = rand_addr();
		second_pc = rand_addr();
		third_pc = rand_addr();
		raise_mem1(1'b1, 1'b0, first_pc);
		settle();
		check_addr("npc on exception", npc, `EXC_VECTOR);
		step();
		exp_pc = `EXC_VECTOR;
		exp_epc = first_pc;
		check_addr("pc after exception", pc, exp_pc);
		idle_inputs();
		settle();
		check_flushes(1'b0, 1'b0, 1'b0);
		step();
		exp_pc = exp_pc + 32'd4;
		raise_mem1(1'b0, 1'b1, rand_addr());
		settle();
		check_addr("npc on eret", npc, exp_epc);
		check_flushes(1'b1, 1'b1, 1'b1);
		step();
		exp_pc = exp_epc;
		check_addr("pc after eret", pc, exp_pc);
		raise_mem1(1'b1, 1'b0, second_pc); // Stalled exception, EPC keeps first_pc
		can_go = 1'b0;
		settle();
		check_flushes(1'b1, 1'b1, 1'b0);
		step();
		check_addr("pc while stalled", pc, exp_pc);
		raise_mem1(1'b0, 1'b1, rand_addr());
		can_go = 1'b1;
		settle();
		check_addr("npc on eret after stall", npc, exp_epc);
		step();
		exp_pc = exp_epc;
		check_addr("pc after eret", pc, exp_pc);
		raise_mem1(1'b1, 1'b1, third_pc);
		settle();
		check_addr("npc on exception with eret", npc, `EXC_VECTOR);
		step();
		exp_pc = `EXC_VECTOR;
		exp_epc = third_pc;
		check_addr("pc after exception", pc, exp_pc);
		raise_mem1(1'b0, 1'b1, rand_addr());
		settle();
		check_addr("npc on eret", npc, exp_epc);
		step();
		exp_pc = exp_epc;
		check_addr("pc after eret", pc, exp_pc);
		idle_inputs();
	endtask

	initial begin
		void'($urandom(18));
		idle_inputs();
		rst = 1'b1;
		exp_pc = `RESET_PC;
		exp_epc = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		test_sequential_fetch();
		test_correct_predict();
		test_mispredict();
		test_exception_priority();
		test_eret_epc();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_redirect_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_redirect_properties
	import fetch_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  can_go,
	input logic  ee,
	input logic  if_flush,
	input logic  id_flush,
	input logic  ex_flush,
	input logic  mem1_flush,
	input addr_t pc
);

	mem1_flush_needs_advance: assert property (@(posedge clk) mem1_flush |-> can_go)
		else $error("mem1_flush is high while can_go is low");

	// Exception or eret kills every younger stage
	ee_kills_front: assert property (@(posedge clk) ee |-> (if_flush && id_flush && ex_flush))
		else $error("ee is high but an IF, ID or EX flush is low");

	reset_loads_boot_pc: assert property (@(posedge clk) rst |=> (pc == `RESET_PC))
		else $error("pc is not the reset address in the cycle after rst");

endmodule

bind fetch_redirect_top fetch_redirect_properties u_properties (
	.clk        (clk),
	.rst        (rst),
	.can_go     (can_go),
	.ee         (ee),
	.if_flush   (if_flush),
	.id_flush   (id_flush),
	.ex_flush   (ex_flush),
	.mem1_flush (mem1_flush),
	.pc         (pc)
);

`default_nettype wire

// File: fetch_redirect_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect_top
	import fetch_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    can_go,
	input  logic    ex_valid,
	input  npc_op_t ex_npc_op,
	input  addr_t   ex_pc,
	input  logic    ex_taken,
	input  addr_t   ex_branch_target,
	input  addr_t   ex_jump_target,
	input  addr_t   ex_ret_addr,
	input  addr_t   ex_fetched_npc,
	input  logic    mem1_exception,
	input  logic    mem1_eret,
	input  addr_t   mem1_pc,
	output addr_t   pc,
	output addr_t   npc,
	output logic    instr_flush,
	output logic    if_flush,
	output logic    id_flush,
	output logic    ex_flush,
	output logic    mem1_flush
);

	addr_t npc_seq;
	addr_t npc_branch;
	addr_t npc_jump;
	addr_t npc_jret;
	logic  flush_seq;
	logic  flush_branch;
	logic  flush_jump;
	logic  flush_jret;
	addr_t target_addr_final;
	logic  ee;
	addr_t npc_ee;

	fetch_pc u_fetch_pc (
		.clk               (clk),
		.rst               (rst),
		.can_go            (can_go),
		.npc               (npc),
		.pc                (pc),
		.target_addr_final (target_addr_final)
	);

	branch_resolve u_branch_resolve (
		.ex_valid         (ex_valid),
		.ex_taken         (ex_taken),
		.ex_pc            (ex_pc),
		.ex_branch_target (ex_branch_target),
		.ex_jump_target   (ex_jump_target),
		.ex_ret_addr      (ex_ret_addr),
		.ex_fetched_npc   (ex_fetched_npc),
		.npc_seq          (npc_seq),
		.npc_branch       (npc_branch),
		.npc_jump         (npc_jump),
		.npc_jret         (npc_jret),
		.flush_seq        (flush_seq),
		.flush_branch     (flush_branch),
		.flush_jump       (flush_jump),
		.flush_jret       (flush_jret)
	);

	exc_flush_ctrl u_exc_flush_ctrl (
		.clk            (clk),
		.rst            (rst),
		.can_go         (can_go),
		.mem1_exception (mem1_exception),
		.mem1_eret      (mem1_eret),
		.mem1_pc        (mem1_pc),
		.ee             (ee),
		.npc_ee         (npc_ee),
		.if_flush       (if_flush),
		.id_flush       (id_flush),
		.ex_flush       (ex_flush),
		.mem1_flush     (mem1_flush)
	);

	npc u_npc (
		.npc_op            (ex_npc_op),
		.npc_seq           (npc_seq),
		.npc_branch        (npc_branch),
		.npc_jump          (npc_jump),
		.npc_jret          (npc_jret),
		.target_addr_final (target_addr_final),
		.npc_ee            (npc_ee),
		.flush_seq         (flush_seq),
		.flush_branch      (flush_branch),
		.flush_jump        (flush_jump),
		.flush_jret        (flush_jret),
		.ee                (ee),
		.npc               (npc),
		.instr_flush       (instr_flush)
	);

endmodule

`default_nettype wire

// File: npc.sv
`timescale 1ns/1ps
`default_nettype none

module npc
	import fetch_pkg::*;
(
	input  npc_op_t npc_op,
	input  addr_t   npc_seq,
	input  addr_t   npc_branch,
	input  addr_t   npc_jump,
	input  addr_t   npc_jret,
	input  addr_t   target_addr_final,
	input  addr_t   npc_ee,
	input  logic    flush_seq,
	input  logic    flush_branch,
	input  logic    flush_jump,
	input  logic    flush_jret,
	input  logic    ee,
	output addr_t   npc,
	output logic    instr_flush
);

	addr_t npc_temp;
	logic  branch_error;

	// Candidate and mispredict flag of the EX instruction
	always_comb begin
		case (npc_op)
			NPC_SEQ: begin
				npc_temp     = npc_seq;
				branch_error = flush_seq;
			end
			NPC_BRANCH: begin
				npc_temp     = npc_branch;
				branch_error = flush_branch;
			end
			NPC_JUMP: begin
				npc_temp     = npc_jump;
				branch_error = flush_jump;
			end
			default: begin
				npc_temp     = npc_jret; // jr
				branch_error = flush_jret;
			end
		endcase
	end

	// Exception or eret, then EX correction, then fall-through
	always_comb begin
		if (ee) begin
			npc = npc_ee;
		end else if (branch_error) begin
			npc = npc_temp;
		end else begin
			npc = target_addr_final;
		end
	end

	assign instr_flush = branch_error | ee;

endmodule

`default_nettype wire

// File: exc_flush_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module exc_flush_ctrl
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  can_go,
	input  logic  mem1_exception,
	input  logic  mem1_eret,
	input  addr_t mem1_pc,
	output logic  ee,
	output addr_t npc_ee,
	output logic  if_flush,
	output logic  id_flush,
	output logic  ex_flush,
	output logic  mem1_flush
);

	addr_t epc;

	// EPC only captures when the faulting instruction really leaves MEM1
	always_ff @(posedge clk) begin
		if (rst) begin
			epc <= '0;
		end else if (mem1_exception && can_go) begin
			epc <= mem1_pc;
		end
	end

	assign ee = mem1_exception | mem1_eret;

	// Exception beats eret in the same cycle
	assign npc_ee = mem1_exception ? addr_t'(`EXC_VECTOR) : epc;

	// Younger stages are killed right away
	assign if_flush = ee;
	assign id_flush = ee;
	assign ex_flush = ee;

	assign mem1_flush = ee & can_go; // Only once MEM1 moves on

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve
	import fetch_pkg::*;
(
	input  logic  ex_valid,
	input  logic  ex_taken,
	input  addr_t ex_pc,
	input  addr_t ex_branch_target,
	input  addr_t ex_jump_target,
	input  addr_t ex_ret_addr,
	input  addr_t ex_fetched_npc,
	output addr_t npc_seq,
	output addr_t npc_branch,
	output addr_t npc_jump,
	output addr_t npc_jret,
	output logic  flush_seq,
	output logic  flush_branch,
	output logic  flush_jump,
	output logic  flush_jret
);

	localparam addr_t INSTR_BYTES = addr_t'(4);

	addr_t ex_pc_plus4;

	// A valid instruction whose real successor is not what fetch picked
	function automatic logic mispredict(
		input logic  valid,
		input addr_t correct,
		input addr_t fetched
	);
		mispredict = valid && (correct != fetched);
	endfunction

	assign ex_pc_plus4 = ex_pc + INSTR_BYTES;

	// Correct successor per transfer kind
	assign npc_seq    = ex_pc_plus4;
	assign npc_branch = ex_taken ? ex_branch_target : ex_pc_plus4; // Fall-through if not taken
	assign npc_jump   = ex_jump_target;
	assign npc_jret   = ex_ret_addr; // jr target from register read

	assign flush_seq    = mispredict(ex_valid, npc_seq, ex_fetched_npc);
	assign flush_branch = mispredict(ex_valid, npc_branch, ex_fetched_npc);
	assign flush_jump   = mispredict(ex_valid, npc_jump, ex_fetched_npc);
	assign flush_jret   = mispredict(ex_valid, npc_jret, ex_fetched_npc);

endmodule

`default_nettype wire

// File: fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  can_go,
	input  addr_t npc,
	output addr_t pc,
	output addr_t target_addr_final
);

	localparam addr_t INSTR_BYTES = addr_t'(4);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC; // Boot address
		end else if (can_go) begin
			pc <= npc;
		end
	end

	// Static not-taken guess, always the next word
	assign target_addr_final = pc + INSTR_BYTES;

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

	// Instruction address as seen by fetch
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// Kind of control transfer sitting in EX
	typedef enum logic [1:0] {
		NPC_SEQ    = 2'b00, // Plain sequential instruction
		NPC_BRANCH = 2'b01, // Conditional branch
		NPC_JUMP   = 2'b10, // Jump to immediate target
		NPC_JRET   = 2'b11  // Jump to register value
	} npc_op_t;

endpackage

`default_nettype wire

// File: fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Instruction address width
`define FETCH_ADDR_W 32

// Boot ROM entry after reset
`define RESET_PC 32'hBFC00000

// General exception entry, fixed since status BEV is not modelled
`define EXC_VECTOR 32'hBFC00380

`endif
